// File: rtl/agu_pkg.sv
package agu_pkg;

   // memory address and iteration count width
   localparam int ADDR_W = 10;

   // period, duty and delay counters
   localparam int PERIOD_W = 6;

   // memory word
   localparam int DATA_W = 16;

   // one config write carries the widest field
   localparam int CFG_DATA_W = ADDR_W;

   // config field select, same code for both ports
   typedef enum logic [2:0] {
      CFG_ITER   = 3'd0,   // number of periods
      CFG_PERIOD = 3'd1,   // cycles per period
      CFG_DUTY   = 3'd2,   // enabled cycles per period
      CFG_DELAY  = 3'd3,   // wait before first period
      CFG_START  = 3'd4,   // first address
      CFG_SHIFT  = 3'd5,   // signed jump at period wrap
      CFG_INCR   = 3'd6    // signed step per enabled cycle
   } cfg_field_e;

   // address generator states
   typedef enum logic {
      AGU_IDLE = 1'b0,
      AGU_RUN  = 1'b1
   } agu_state_e;

endpackage

// File: rtl/addr_gen.sv
module addr_gen (
   input  logic                              clk,
   input  logic                              rst,
   input  logic                              init,
   input  logic                              run,

   input  logic        [agu_pkg::ADDR_W-1:0]   iterations,
   input  logic        [agu_pkg::PERIOD_W-1:0] period,
   input  logic        [agu_pkg::PERIOD_W-1:0] duty,
   input  logic        [agu_pkg::PERIOD_W-1:0] delay,
   input  logic        [agu_pkg::ADDR_W-1:0]   start,
   input  logic signed [agu_pkg::ADDR_W-1:0]   shift,
   input  logic signed [agu_pkg::ADDR_W-1:0]   incr,

   output logic        [agu_pkg::ADDR_W-1:0]   addr,
   output logic                              mem_en,
   output logic                              done
);

   import agu_pkg::*;

   agu_state_e state, state_nxt;

   logic signed [PERIOD_W:0] per_cnt, per_cnt_nxt;   // counts up through zero after delay
   logic signed [PERIOD_W:0] period_int, duty_int, delay_int;

   logic [ADDR_W-1:0] iter, iter_nxt;   // current period, 1-based
   logic [ADDR_W-1:0] addr_nxt;
   logic              mem_en_nxt;
   logic              done_nxt;

   logic per_wrap;
   logic last_iter;

   assign period_int = signed'({1'b0, period});
   assign duty_int   = signed'({1'b0, duty});
   assign delay_int  = signed'({1'b0, delay});

   assign per_wrap  = (per_cnt == period_int);
   assign last_iter = (iter == iterations);

   always_comb begin
      state_nxt   = state;
      done_nxt    = done;
      mem_en_nxt  = mem_en;
      per_cnt_nxt = per_cnt;
      addr_nxt    = addr;
      iter_nxt    = iter;

      if (state == AGU_IDLE) begin
         if (init) begin
            per_cnt_nxt = (PERIOD_W+1)'(1) - delay_int;
            addr_nxt    = start;
            iter_nxt    = ADDR_W'(1);
         end

         if (run) begin
            state_nxt = AGU_RUN;
            done_nxt  = 1'b0;
            if (delay == '0)
               mem_en_nxt = 1'b1;   // no wait, first burst starts now
         end
      end else begin
         // enable at end of delay or at a wrap into another period
         if (per_cnt == '0 || (per_wrap && !last_iter))
            mem_en_nxt = 1'b1;

         // end of burst, unless bursts run back to back
         if (per_cnt == duty_int && (period != duty || last_iter))
            mem_en_nxt = 1'b0;

         if (per_wrap) begin
            per_cnt_nxt = (PERIOD_W+1)'(1);
            iter_nxt    = iter + ADDR_W'(1);
         end else begin
            per_cnt_nxt = per_cnt + (PERIOD_W+1)'(1);
         end

         if (mem_en)
            addr_nxt = addr + incr;

         if (per_wrap)
            addr_nxt = addr + incr + shift;

         // hold the last burst address until the wrap
         if (mem_en && per_cnt == duty_int && period != duty)
            addr_nxt = addr;

         if (last_iter && per_wrap) begin
            state_nxt = AGU_IDLE;
            done_nxt  = 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state   <= AGU_IDLE;
         mem_en  <= 1'b0;
         done    <= 1'b1;
         addr    <= '0;
         per_cnt <= '0;
         iter    <= '0;
      end else begin
         state   <= state_nxt;
         mem_en  <= mem_en_nxt;
         done    <= done_nxt;
         addr    <= addr_nxt;
         per_cnt <= per_cnt_nxt;
         iter    <= iter_nxt;
      end
   end

endmodule

// File: rtl/agu_conf_regs.sv
module agu_conf_regs (
   input  logic                                 clk,
   input  logic                                 rst,
   input  logic                                 cfg_we,
   input  logic                                 cfg_port,   // 0 read gen, 1 write gen
   input  agu_pkg::cfg_field_e                  cfg_field,
   input  logic        [agu_pkg::CFG_DATA_W-1:0] cfg_data,

   // read generator
   output logic        [agu_pkg::ADDR_W-1:0]     iterations_a,
   output logic        [agu_pkg::PERIOD_W-1:0]   period_a,
   output logic        [agu_pkg::PERIOD_W-1:0]   duty_a,
   output logic        [agu_pkg::PERIOD_W-1:0]   delay_a,
   output logic        [agu_pkg::ADDR_W-1:0]     start_a,
   output logic signed [agu_pkg::ADDR_W-1:0]     shift_a,
   output logic signed [agu_pkg::ADDR_W-1:0]     incr_a,

   // write generator
   output logic        [agu_pkg::ADDR_W-1:0]     iterations_b,
   output logic        [agu_pkg::PERIOD_W-1:0]   period_b,
   output logic        [agu_pkg::PERIOD_W-1:0]   duty_b,
   output logic        [agu_pkg::PERIOD_W-1:0]   delay_b,
   output logic        [agu_pkg::ADDR_W-1:0]     start_b,
   output logic signed [agu_pkg::ADDR_W-1:0]     shift_b,
   output logic signed [agu_pkg::ADDR_W-1:0]     incr_b
);

   import agu_pkg::*;

   logic [6:0] we_a;   // one bit per field, indexed by cfg_field
   logic [6:0] we_b;

   always_comb begin
      we_a = '0;
      we_b = '0;
      if (cfg_we) begin
         if (cfg_port)
            we_b[cfg_field] = 1'b1;
         else
            we_a[cfg_field] = 1'b1;
      end
   end

   // port a fields
   always_ff @(posedge clk) begin
      if (rst) begin
         iterations_a <= '0;
         period_a     <= '0;
         duty_a       <= '0;
         delay_a      <= '0;
         start_a      <= '0;
         shift_a      <= '0;
         incr_a       <= '0;
      end else begin
         if (we_a[CFG_ITER])   iterations_a <= cfg_data[ADDR_W-1:0];
         if (we_a[CFG_PERIOD]) period_a     <= cfg_data[PERIOD_W-1:0];
         if (we_a[CFG_DUTY])   duty_a       <= cfg_data[PERIOD_W-1:0];
         if (we_a[CFG_DELAY])  delay_a      <= cfg_data[PERIOD_W-1:0];
         if (we_a[CFG_START])  start_a      <= cfg_data[ADDR_W-1:0];
         if (we_a[CFG_SHIFT])  shift_a      <= signed'(cfg_data[ADDR_W-1:0]);
         if (we_a[CFG_INCR])   incr_a       <= signed'(cfg_data[ADDR_W-1:0]);
      end
   end

   // port b fields
   always_ff @(posedge clk) begin
      if (rst) begin
         iterations_b <= '0;
         period_b     <= '0;
         duty_b       <= '0;
         delay_b      <= '0;
         start_b      <= '0;
         shift_b      <= '0;
         incr_b       <= '0;
      end else begin
         if (we_b[CFG_ITER])   iterations_b <= cfg_data[ADDR_W-1:0];
         if (we_b[CFG_PERIOD]) period_b     <= cfg_data[PERIOD_W-1:0];
         if (we_b[CFG_DUTY])   duty_b       <= cfg_data[PERIOD_W-1:0];
         if (we_b[CFG_DELAY])  delay_b      <= cfg_data[PERIOD_W-1:0];
         if (we_b[CFG_START])  start_b      <= cfg_data[ADDR_W-1:0];
         if (we_b[CFG_SHIFT])  shift_b      <= signed'(cfg_data[ADDR_W-1:0]);
         if (we_b[CFG_INCR])   incr_b       <= signed'(cfg_data[ADDR_W-1:0]);
      end
   end

endmodule

// File: rtl/dp_ram.sv
module dp_ram #(
   parameter int addr_w = agu_pkg::ADDR_W   // depth is 2**addr_w words
) (
   input  logic                       clk,
   input  logic                       rst,
   input  logic                       wr_en,
   input  logic [addr_w-1:0]          wr_addr,
   input  logic [agu_pkg::DATA_W-1:0] wr_data,
   input  logic                       rd_en,
   input  logic [addr_w-1:0]          rd_addr,
   output logic [agu_pkg::DATA_W-1:0] rd_data,
   output logic                       rd_valid
);

   import agu_pkg::*;

   logic [DATA_W-1:0] mem [0:(2**addr_w)-1];

   always_ff @(posedge clk) begin
      if (wr_en)
         mem[wr_addr] <= wr_data;
      if (rd_en)
         rd_data <= mem[rd_addr];   // one cycle read latency
   end

   always_ff @(posedge clk) begin
      if (rst)
         rd_valid <= 1'b0;
      else
         rd_valid <= rd_en;
   end

endmodule

// File: rtl/agu_mem_unit.sv
module agu_mem_unit (
   input  logic                           clk,
   input  logic                           rst,
   input  logic                           cfg_we,
   input  logic                           cfg_port,
   input  agu_pkg::cfg_field_e            cfg_field,
   input  logic [agu_pkg::CFG_DATA_W-1:0] cfg_data,
   input  logic                           init_a,
   input  logic                           run_a,
   input  logic                           init_b,
   input  logic                           run_b,
   input  logic [agu_pkg::DATA_W-1:0]     wr_data,
   output logic [agu_pkg::DATA_W-1:0]     rd_data,
   output logic                           rd_valid,
   output logic                           done_a,
   output logic                           done_b
);

   import agu_pkg::*;

   logic        [ADDR_W-1:0]   iterations_a, iterations_b;
   logic        [PERIOD_W-1:0] period_a, period_b;
   logic        [PERIOD_W-1:0] duty_a, duty_b;
   logic        [PERIOD_W-1:0] delay_a, delay_b;
   logic        [ADDR_W-1:0]   start_a, start_b;
   logic signed [ADDR_W-1:0]   shift_a, shift_b;
   logic signed [ADDR_W-1:0]   incr_a, incr_b;

   logic [ADDR_W-1:0] rd_addr, wr_addr;
   logic              rd_en, wr_en;

   agu_conf_regs u_conf_regs (
      .clk          (clk),
      .rst          (rst),
      .cfg_we       (cfg_we),
      .cfg_port     (cfg_port),
      .cfg_field    (cfg_field),
      .cfg_data     (cfg_data),
      .iterations_a (iterations_a),
      .period_a     (period_a),
      .duty_a       (duty_a),
      .delay_a      (delay_a),
      .start_a      (start_a),
      .shift_a      (shift_a),
      .incr_a       (incr_a),
      .iterations_b (iterations_b),
      .period_b     (period_b),
      .duty_b       (duty_b),
      .delay_b      (delay_b),
      .start_b      (start_b),
      .shift_b      (shift_b),
      .incr_b       (incr_b)
   );

   // port a streams reads
   addr_gen u_gen_rd (
      .clk        (clk),
      .rst        (rst),
      .init       (init_a),
      .run        (run_a),
      .iterations (iterations_a),
      .period     (period_a),
      .duty       (duty_a),
      .delay      (delay_a),
      .start      (start_a),
      .shift      (shift_a),
      .incr       (incr_a),
      .addr       (rd_addr),
      .mem_en     (rd_en),
      .done       (done_a)
   );

   // port b streams writes
   addr_gen u_gen_wr (
      .clk        (clk),
      .rst        (rst),
      .init       (init_b),
      .run        (run_b),
      .iterations (iterations_b),
      .period     (period_b),
      .duty       (duty_b),
      .delay      (delay_b),
      .start      (start_b),
      .shift      (shift_b),
      .incr       (incr_b),
      .addr       (wr_addr),
      .mem_en     (wr_en),
      .done       (done_b)
   );

   dp_ram #(
      .addr_w (ADDR_W)
   ) u_ram (
      .clk      (clk),
      .rst      (rst),
      .wr_en    (wr_en),
      .wr_addr  (wr_addr),
      .wr_data  (wr_data),   // straight from outside
      .rd_en    (rd_en),
      .rd_addr  (rd_addr),
      .rd_data  (rd_data),
      .rd_valid (rd_valid)
   );

endmodule

// File: testbench/tb_agu_mem.sv
module tb_agu_mem;

   timeunit 1ns;
   timeprecision 1ps;

   import agu_pkg::*;

   typedef struct packed {
      logic [ADDR_W-1:0]   iter;
      logic [PERIOD_W-1:0] period;
      logic [PERIOD_W-1:0] duty;
      logic [PERIOD_W-1:0] delay;
      logic [ADDR_W-1:0]   start;
      logic [ADDR_W-1:0]   shift;   // two's complement
      logic [ADDR_W-1:0]   incr;    // two's complement
   } gen_cfg_t;

   typedef struct packed {
      gen_cfg_t wr;
      gen_cfg_t rd;
      logic     do_write;     // port b runs before port a
      logic     all_fields;   // else only start and incr of port a
   } test_t;

   logic                  clk;
   logic                  rst;
   logic                  cfg_we;
   logic                  cfg_port;
   cfg_field_e            cfg_field;
   logic [CFG_DATA_W-1:0] cfg_data;
   logic                  init_a;
   logic                  run_a;
   logic                  init_b;
   logic                  run_b;
   logic [DATA_W-1:0]     wr_data;
   logic [DATA_W-1:0]     rd_data;
   logic                  rd_valid;
   logic                  done_a;
   logic                  done_b;

   logic [DATA_W-1:0] shadow [0:(2**ADDR_W)-1];   // expected memory contents
   logic [31:0]       lfsr_state;
   test_t             tests [6];
   logic              table_ready;

   agu_mem_unit DUT (
      .clk       (clk),
      .rst       (rst),
      .cfg_we    (cfg_we),
      .cfg_port  (cfg_port),
      .cfg_field (cfg_field),
      .cfg_data  (cfg_data),
      .init_a    (init_a),
      .run_a     (run_a),
      .init_b    (init_b),
      .run_b     (run_b),
      .wr_data   (wr_data),
      .rd_data   (rd_data),
      .rd_valid  (rd_valid),
      .done_a    (done_a),
      .done_b    (done_b)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   function automatic gen_cfg_t make_cfg(input int iter, input int period, input int duty,
                                         input int delay, input int start, input int shift,
                                         input int incr);
      gen_cfg_t c;
      c.iter   = ADDR_W'(iter);
      c.period = PERIOD_W'(period);
      c.duty   = PERIOD_W'(duty);
      c.delay  = PERIOD_W'(delay);
      c.start  = ADDR_W'(start);
      c.shift  = ADDR_W'(shift);
      c.incr   = ADDR_W'(incr);
      return c;
   endfunction

   task automatic build_table();
      // linear bursts back to back
      tests[0] = '{wr: make_cfg(4, 8, 8, 0, 16, 0, 1), rd: make_cfg(4, 8, 8, 0, 16, 0, 1),
                   do_write: 1'b1, all_fields: 1'b1};
      // gapped bursts with reads walking blocks backwards
      tests[1] = '{wr: make_cfg(4, 6, 3, 0, 100, 0, 1), rd: make_cfg(3, 7, 4, 2, 108, -8, 1),
                   do_write: 1'b1, all_fields: 1'b1};
      // delay and a step of -2 on the read side
      tests[2] = '{wr: make_cfg(2, 5, 5, 3, 200, 0, 2), rd: make_cfg(5, 3, 2, 5, 218, 0, -2),
                   do_write: 1'b1, all_fields: 1'b1};
      // crosses the top of the address space both ways
      tests[3] = '{wr: make_cfg(3, 4, 4, 1, 1020, 0, 1), rd: make_cfg(2, 6, 6, 0, 7, 0, -1),
                   do_write: 1'b1, all_fields: 1'b1};
      tests[4] = '{wr: make_cfg(3, 4, 4, 1, 1020, 0, 1), rd: make_cfg(2, 6, 6, 0, 1020, 0, 1),
                   do_write: 1'b0, all_fields: 1'b0};
      // positive shift on writes and interleaved reads
      tests[5] = '{wr: make_cfg(3, 4, 2, 2, 300, 5, 3), rd: make_cfg(2, 3, 3, 0, 300, -30, 11),
                   do_write: 1'b1, all_fields: 1'b1};
   endtask

   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   task automatic draw_word(output logic [DATA_W-1:0] w);
      w = '0;
      for (int i = 0; i < DATA_W; i++) begin
         w          = {lfsr_state[0], w[DATA_W-1:1]};
         lfsr_state = lfsr_step(lfsr_state);
      end
   endtask

   // cycles from the run edge until done rises again
   function automatic int run_span(input gen_cfg_t c);
      return int'(c.delay) + int'(c.iter) * int'(c.period);
   endfunction

   // enable of cycle t after the run edge with its period and slot
   function automatic logic burst_slot(input gen_cfg_t c, input int t,
                                       output int k, output int j);
      int u;
      u = t - int'(c.delay);
      k = 0;
      j = 0;
      if (u < 0)
         return 1'b0;
      k = u / int'(c.period);
      j = u % int'(c.period);
      return (k < int'(c.iter)) && (j < int'(c.duty));
   endfunction

   function automatic logic [ADDR_W-1:0] model_addr(input gen_cfg_t c, input int k, input int j);
      int a;
      int step;
      step = int'($signed(c.incr));
      a = int'(c.start) + k * (int'(c.duty) * step + int'($signed(c.shift))) + j * step;
      return a[ADDR_W-1:0];   // low bits give the modulo
   endfunction

   task automatic check_data(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp,
                             input string what);
      if (got !== exp) begin
         $display("Mismatch at %0t: %s, got %h, expected %h", $time, what, got, exp);
         $display("TEST FAILED");
         $fatal(1, "data check failed");
      end
   endtask

   task automatic check_count(input int got, input int exp, input string what);
      if (got != exp) begin
         $display("Mismatch at %0t: %s, got %0d, expected %0d", $time, what, got, exp);
         $display("TEST FAILED");
         $fatal(1, "count check failed");
      end
   endtask

   task automatic check_done(input logic got, input logic exp, input string what);
      if (got !== exp) begin
         $display("Mismatch at %0t: %s, got %b, expected %b", $time, what, got, exp);
         $display("TEST FAILED");
         $fatal(1, "level check failed");
      end
   endtask

   task automatic write_field(input logic port, input cfg_field_e field,
                              input logic [CFG_DATA_W-1:0] data);
      @(posedge clk);
      cfg_we    <= 1'b1;
      cfg_port  <= port;
      cfg_field <= field;
      cfg_data  <= data;
   endtask

   task automatic write_gen(input logic port, input gen_cfg_t c);
      write_field(port, CFG_ITER, CFG_DATA_W'(c.iter));
      write_field(port, CFG_PERIOD, CFG_DATA_W'(c.period));
      write_field(port, CFG_DUTY, CFG_DATA_W'(c.duty));
      write_field(port, CFG_DELAY, CFG_DATA_W'(c.delay));
      write_field(port, CFG_START, CFG_DATA_W'(c.start));
      write_field(port, CFG_SHIFT, CFG_DATA_W'(c.shift));
      write_field(port, CFG_INCR, CFG_DATA_W'(c.incr));
   endtask

   task automatic write_config(input test_t tc);
      if (tc.all_fields) begin
         write_gen(1'b1, tc.wr);
         write_gen(1'b0, tc.rd);
      end else begin
         write_field(1'b0, CFG_START, CFG_DATA_W'(tc.rd.start));
         write_field(1'b0, CFG_INCR, CFG_DATA_W'(tc.rd.incr));
      end
      @(posedge clk);
      cfg_we <= 1'b0;
   endtask

   task automatic run_write(input gen_cfg_t c);
      logic [DATA_W-1:0] word;
      int                t;
      int                k;
      int                j;
      logic              busy;
      @(posedge clk);
      init_b <= 1'b1;
      run_b  <= 1'b1;
      @(posedge clk);   // pulses registered here as cycle 0 begins
      init_b <= 1'b0;
      run_b  <= 1'b0;
      t    = 0;
      busy = 1'b1;
      while (busy) begin
         draw_word(word);
         wr_data <= word;
         if (burst_slot(c, t, k, j))
            shadow[model_addr(c, k, j)] = word;
         @(negedge clk);
         if (t == 0)
            check_done(done_b, 1'b0, "done_b after run");
         busy = !done_b;
         if (busy) begin
            @(posedge clk);
            t++;
         end
      end
      check_count(t, run_span(c), "cycles with done_b low");
   endtask

   task automatic run_read(input gen_cfg_t c);
      int                exp_cyc[$];
      logic [DATA_W-1:0] exp_word[$];
      int                t;
      int                k;
      int                j;
      int                n;
      logic              busy;
      for (t = 0; t < run_span(c); t++) begin
         if (burst_slot(c, t, k, j)) begin
            exp_cyc.push_back(t + 1);   // valid trails the enable by one
            exp_word.push_back(shadow[model_addr(c, k, j)]);
         end
      end
      @(posedge clk);
      init_a <= 1'b1;
      run_a  <= 1'b1;
      @(posedge clk);
      init_a <= 1'b0;
      run_a  <= 1'b0;
      t    = 0;
      n    = 0;
      busy = 1'b1;
      while (busy) begin
         @(negedge clk);
         if (t == 0)
            check_done(done_a, 1'b0, "done_a after run");
         if (rd_valid) begin
            if (n < exp_cyc.size()) begin
               check_count(t, exp_cyc[n], "cycle of rd_valid");
               check_data(rd_data, exp_word[n], "rd_data");
            end
            n++;
         end
         busy = !done_a;
         if (busy) begin
            @(posedge clk);
            t++;
         end
      end
      check_count(t, run_span(c), "cycles with done_a low");
      check_count(n, int'(c.iter) * int'(c.duty), "rd_valid pulses");
   endtask

   initial begin
      int limit;
      wait (table_ready === 1'b1);
      limit = 16 + 20;
      for (int i = 0; i < $size(tests); i++) begin
         limit += run_span(tests[i].wr) + 20;
         limit += run_span(tests[i].rd) + 20;
         limit += 40;   // config writes and pulses
      end
      repeat (limit) @(posedge clk);
      $display("Run did not finish within %0d clock cycles", limit);
      $display("TEST FAILED");
      $fatal(1, "watchdog timeout");
   end

   initial begin
      rst       <= 1'b1;
      cfg_we    <= 1'b0;
      cfg_port  <= 1'b0;
      cfg_field <= CFG_ITER;
      cfg_data  <= '0;
      init_a    <= 1'b0;
      run_a     <= 1'b0;
      init_b    <= 1'b0;
      run_b     <= 1'b0;
      wr_data   <= '0;
      lfsr_state  = 32'h2ae1_360a;
      table_ready = 1'b0;
      build_table();
      table_ready = 1'b1;
      repeat (16) @(posedge clk);
      rst <= 1'b0;
      @(negedge clk);
      check_done(done_a, 1'b1, "done_a after reset");
      check_done(done_b, 1'b1, "done_b after reset");
      check_done(rd_valid, 1'b0, "rd_valid after reset");
      for (int i = 0; i < $size(tests); i++) begin
         write_config(tests[i]);
         if (tests[i].do_write)
            run_write(tests[i].wr);
         run_read(tests[i].rd);
      end
      $display("TEST OK");
      $finish;
   end

endmodule

// File: agu_mem.f
rtl/agu_pkg.sv
rtl/addr_gen.sv
rtl/agu_conf_regs.sv
rtl/dp_ram.sv
rtl/agu_mem_unit.sv
testbench/tb_agu_mem.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --timescale 1ns/1ps \
   -f agu_mem.f \
   --top-module tb_agu_mem \
   -o sim_agu_mem

./obj_dir/sim_agu_mem | tee sim.log

if grep -qx "TEST OK" sim.log; then
   echo "simulation passed"
   exit 0
else
   echo "simulation failed, see sim.log"
   exit 1
fi
